/* Bender.yml */
package:
  name: fm_regs

sources:
  - include_dirs:
      - .
    files:
      - fm_regs_pkg.sv
      - fm_mmr.sv
      - fm_timers.sv
      - fm_slot_arbiter.sv
      - fm_slot_ram.sv
      - fm_slot_scan.sv
      - fm_regs_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fm_regs_assert.sv
      - tb_fm_regs.sv

/* fm_mmr.sv */
//******************************
// Host register decoder
// Address/data latching with busy handshake, global
// registers and slot write generation for the
// operator and channel register ranges
//******************************
`timescale 1ns/1ps
`default_nettype none
`include "fm_regs_defines.svh"

module fm_mmr import fm_regs_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        cen,
	input  host_wr_t    wr,
	output logic        busy,
	output slot_req_t   wr_req,
	input  logic        wr_gnt,
	output logic [23:0] keyon,
	output logic [9:0]  value_a,
	output logic [7:0]  value_b,
	output logic [5:0]  timer_ctl,
	output logic        timer_wr,
	output logic [3:0]  lfo,
	output logic [8:0]  pcm,
	output logic        pcm_en,
	output logic        eg_stop,
	output logic        pg_stop
);

	logic [7:0]   sel_reg;
	logic         bank;
	logic [7:0]   din_lat;
	logic [7:0]   blk_lat;
	logic         req_q;
	logic         multi_q;
	logic [1:0]   op_cnt;
	logic [9:0]   be_q;
	logic         accept;
	logic [2:0]   reg_ch;
	logic [1:0]   reg_op;
	logic [2:0]   kon_ch;
	slot_params_t wdata;

	assign accept = wr.write && !busy;

	// Bank 1 holds channels 3 to 5
	assign reg_ch = bank ? {1'b0, sel_reg[1:0]} + 3'd3 : {1'b0, sel_reg[1:0]};
	// Address field order is operator 1, 3, 2, 4
	assign reg_op = {sel_reg[2], sel_reg[3]};
	assign kon_ch = wr.din[2] ? {1'b0, wr.din[1:0]} + 3'd3 : {1'b0, wr.din[1:0]};

	// Same byte on every lane, be picks the target
	always_comb begin
		wdata = {10{din_lat}};
		wdata.block_fnum_hi = blk_lat;
	end

	always_comb begin
		wr_req.req   = req_q;
		wr_req.we    = 1'b1;
		wr_req.slot  = multi_q ? {reg_ch, op_cnt} : {reg_ch, reg_op};
		wr_req.be    = be_q;
		wr_req.wdata = wdata;
	end

	always_ff @(posedge clk) begin
		if (cen) begin
			if (rst) begin
				sel_reg   <= 8'h00;
				bank      <= 1'b0;
				busy      <= 1'b0;
				req_q     <= 1'b0;
				multi_q   <= 1'b0;
				op_cnt    <= 2'd0;
				keyon     <= '0;
				value_a   <= '0;
				value_b   <= '0;
				timer_ctl <= '0;
				timer_wr  <= 1'b0;
				lfo       <= '0;
				pcm       <= '0;
				pcm_en    <= 1'b0;
				eg_stop   <= 1'b0;
				pg_stop   <= 1'b0;
			end else begin
				timer_wr <= 1'b0;
				// Held until the last slot write lands
				busy     <= accept ? 1'b1 : req_q;

				// Walk the operators of a channel write
				if (req_q && wr_gnt) begin
					if (!multi_q || op_cnt == 2'd3)
						req_q <= 1'b0;
					op_cnt <= op_cnt + 2'd1;
				end

				if (accept && !wr.addr[0]) begin
					sel_reg <= wr.din;
					bank    <= wr.addr[1];
				end else if (accept) begin
					din_lat <= wr.din;
					op_cnt  <= 2'd0;
					if (sel_reg < 8'h30) begin
						case (sel_reg)
						`FM_REG_KON: begin
							// Channel codes 3 and 7 do not exist
							if (wr.din[1:0] != 2'b11)
								keyon[{kon_ch, 2'b00} +: 4] <= wr.din[7:4];
						end
						`FM_REG_TIMER: begin
							timer_ctl <= wr.din[5:0];
							timer_wr  <= 1'b1;
						end
						`FM_REG_CLKA1:  value_a[9:2] <= wr.din;
						`FM_REG_CLKA2:  value_a[1:0] <= wr.din[1:0];
						`FM_REG_CLKB:   value_b      <= wr.din;
						`FM_REG_LFO:    lfo          <= wr.din[3:0];
						`FM_REG_PCM:    pcm[8:1]     <= wr.din;
						`FM_REG_PCM_EN: pcm_en       <= wr.din[7];
						`FM_REG_TESTYM: begin
							eg_stop <= wr.din[5];
							pg_stop <= wr.din[3];
						end
						default: ;
						endcase
					end else if (sel_reg[1:0] != 2'b11 && sel_reg < 8'hA0) begin
						// Register row 3h..9h maps to lanes 9..3
						req_q   <= 1'b1;
						multi_q <= 1'b0;
						be_q    <= 10'd1 << (4'd12 - sel_reg[7:4]);
					end else if (sel_reg[1:0] != 2'b11) begin
						case ({sel_reg[7:2], 2'b00})
						8'hA0: begin
							req_q   <= 1'b1;
							multi_q <= 1'b1;
							be_q    <= 10'b00_0000_0110;
						end
						8'hA4: blk_lat <= wr.din;
						8'hB0: begin
							req_q   <= 1'b1;
							multi_q <= 1'b1;
							be_q    <= 10'b00_0000_0001;
						end
						default: ;
						endcase
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* fm_regs.f */
+incdir+.
fm_regs_pkg.sv
fm_mmr.sv
fm_timers.sv
fm_slot_arbiter.sv
fm_slot_ram.sv
fm_slot_scan.sv
fm_regs_top.sv
fm_regs_assert.sv
tb_fm_regs.sv

/* fm_regs_assert.sv */
//******************************
// Concurrent checks on the FM register front end
// Bound into the top level and keeps a count
// of failed checks
//******************************
`timescale 1ns/1ps
`default_nettype none
`include "fm_regs_defines.svh"

module fm_regs_assert import fm_regs_pkg::*; (
	input logic      clk,
	input logic      rst,
	input logic      cen,
	input host_wr_t  wr,
	input logic      busy,
	input slot_req_t wr_req,
	input slot_out_t slot_out
);

	localparam logic [`FM_SLOT_BITS-1:0] LAST_SLOT = `FM_SLOT_BITS'(`FM_NUM_SLOTS - 1);

	int                       error_count = 0;
	logic [`FM_SLOT_BITS-1:0] prev_slot;
	logic [`FM_SLOT_BITS-1:0] next_slot;
	logic                     have_prev;

	assign next_slot = (prev_slot == LAST_SLOT) ? '0 : prev_slot + 1'b1;

	// Slot of the last valid scanner output
	always_ff @(posedge clk) begin
		if (cen) begin
			if (rst) begin
				have_prev <= 1'b0;
				prev_slot <= '0;
			end else if (slot_out.valid) begin
				have_prev <= 1'b1;
				prev_slot <= slot_out.slot;
			end
		end
	end

	property reset_state;
		@(posedge clk) (cen && rst) |=> (!busy && !slot_out.valid);
	endproperty

	property slot_order;
		@(posedge clk) disable iff (rst)
			(cen && slot_out.valid && have_prev) |-> (slot_out.slot == next_slot);
	endproperty

	// An ignored write leaves the pending slot write alone
	property ignored_write;
		@(posedge clk) disable iff (rst)
			(cen && wr.write && busy) |=> ($stable(wr_req.wdata) && $stable(wr_req.be));
	endproperty

	reset_state_chk: assert property (reset_state) else begin
		$error("busy or scanner valid set after reset");
		error_count++;
	end

	slot_order_chk: assert property (slot_order) else begin
		$error("scanner slot did not advance by one");
		error_count++;
	end

	ignored_write_chk: assert property (ignored_write) else begin
		$error("write while busy changed the slot write request");
		error_count++;
	end

endmodule

bind fm_regs_top fm_regs_assert fm_regs_assert_inst (
	.clk      (clk),
	.rst      (rst),
	.cen      (cen),
	.wr       (wr),
	.busy     (busy),
	.wr_req   (wr_req),
	.slot_out (slot_out)
);

`default_nettype wire

/* fm_regs_defines.svh */
//******************************
// Shared constants of the FM register front end
// Included wherever slot counts, global register
// addresses or timer prescales are needed
//******************************
`ifndef FM_REGS_DEFINES_SVH
`define FM_REGS_DEFINES_SVH

// Slot space, one slot per operator of six channels
`define FM_NUM_SLOTS        24
`define FM_SLOT_BITS        5

// Enabled cycles per timer tick
`define FM_TIMER_A_PRESCALE 6
`define FM_TIMER_B_PRESCALE 96

// Global register addresses
`define FM_REG_TESTYM       8'h21
`define FM_REG_LFO          8'h22
`define FM_REG_CLKA1        8'h24
`define FM_REG_CLKA2        8'h25
`define FM_REG_CLKB         8'h26
`define FM_REG_TIMER        8'h27
`define FM_REG_KON          8'h28
`define FM_REG_PCM          8'h2A
`define FM_REG_PCM_EN       8'h2B

`endif

/* fm_regs_pkg.sv */
//******************************
// Types shared by the FM register front end
// Host write, slot memory request, slot parameters
// and scanner output, imported by the modules
//******************************
`default_nettype none
`include "fm_regs_defines.svh"

package fm_regs_pkg;

	// One host bus cycle
	typedef struct packed {
		logic       write;
		logic [1:0] addr;
		logic [7:0] din;
	} host_wr_t;

	// Byte lane 9 is dt_mul, lane 0 is fb_alg; be bit n enables lane n
	typedef struct packed {
		logic [7:0] dt_mul;
		logic [7:0] tl;
		logic [7:0] ks_ar;
		logic [7:0] am_d1r;
		logic [7:0] d2r;
		logic [7:0] d1l_rr;
		logic [7:0] ssg_eg;
		// Channel bytes, copied into all four slots of a channel
		logic [7:0] fnum_lo;
		logic [7:0] block_fnum_hi;
		logic [7:0] fb_alg;
	} slot_params_t;

	typedef struct packed {
		logic                     req;
		logic                     we;
		logic [`FM_SLOT_BITS-1:0] slot;
		logic [9:0]               be;
		slot_params_t             wdata;
	} slot_req_t;

	typedef struct packed {
		logic                     valid;
		logic [`FM_SLOT_BITS-1:0] slot;
		logic [2:0]               ch;
		logic [1:0]               op;
		logic                     keyon;
		slot_params_t             params;
	} slot_out_t;

endpackage

`default_nettype wire

/* fm_regs_top.sv */
//******************************
// FM register front end, top level
// Host port decoder, timers and the shared slot
// memory with its writer and scanner
//******************************
`timescale 1ns/1ps
`default_nettype none

module fm_regs_top import fm_regs_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       cen,
	input  host_wr_t   wr,
	output logic       busy,
	output slot_out_t  slot_out,
	output logic       flag_a,
	output logic       flag_b,
	output logic       irq,
	output logic [3:0] lfo,
	output logic [8:0] pcm,
	output logic       pcm_en,
	output logic       eg_stop,
	output logic       pg_stop
);

	slot_req_t    wr_req;
	slot_req_t    rd_req;
	slot_req_t    mem_req;
	logic         wr_gnt;
	logic         rd_gnt;
	slot_params_t rdata;
	logic [23:0]  keyon;
	logic [9:0]   value_a;
	logic [7:0]   value_b;
	logic [5:0]   timer_ctl;
	logic         timer_wr;

	fm_mmr fm_mmr_inst (
		.clk       (clk),
		.rst       (rst),
		.cen       (cen),
		.wr        (wr),
		.busy      (busy),
		.wr_req    (wr_req),
		.wr_gnt    (wr_gnt),
		.keyon     (keyon),
		.value_a   (value_a),
		.value_b   (value_b),
		.timer_ctl (timer_ctl),
		.timer_wr  (timer_wr),
		.lfo       (lfo),
		.pcm       (pcm),
		.pcm_en    (pcm_en),
		.eg_stop   (eg_stop),
		.pg_stop   (pg_stop)
	);

	fm_timers fm_timers_inst (
		.clk       (clk),
		.rst       (rst),
		.cen       (cen),
		.value_a   (value_a),
		.value_b   (value_b),
		.timer_ctl (timer_ctl),
		.timer_wr  (timer_wr),
		.flag_a    (flag_a),
		.flag_b    (flag_b),
		.irq       (irq)
	);

	fm_slot_arbiter fm_slot_arbiter_inst (
		.wr_req  (wr_req),
		.rd_req  (rd_req),
		.wr_gnt  (wr_gnt),
		.rd_gnt  (rd_gnt),
		.mem_req (mem_req)
	);

	fm_slot_ram fm_slot_ram_inst (
		.clk     (clk),
		.cen     (cen),
		.mem_req (mem_req),
		.rdata   (rdata)
	);

	fm_slot_scan fm_slot_scan_inst (
		.clk      (clk),
		.rst      (rst),
		.cen      (cen),
		.rd_req   (rd_req),
		.rd_gnt   (rd_gnt),
		.rdata    (rdata),
		.keyon    (keyon),
		.slot_out (slot_out)
	);

endmodule

`default_nettype wire

/* fm_slot_arbiter.sv */
//******************************
// Slot memory port arbiter
// Fixed priority, the register writer beats the
// scanner; grants and the memory request are
// combinational so a grant lands on the same edge
//******************************
`timescale 1ns/1ps
`default_nettype none

module fm_slot_arbiter import fm_regs_pkg::*; (
	input  slot_req_t wr_req,
	input  slot_req_t rd_req,
	output logic      wr_gnt,
	output logic      rd_gnt,
	output slot_req_t mem_req
);

	// Writer first, a waiting host write must not starve
	always_comb begin
		wr_gnt = wr_req.req;
		rd_gnt = rd_req.req && !wr_req.req;
	end

	// Winning request goes straight to the memory port
	always_comb begin
		if (wr_gnt) begin
			mem_req = wr_req;
		end else begin
			mem_req     = rd_req;
			mem_req.req = rd_gnt;
		end
	end

endmodule

`default_nettype wire

/* fm_slot_ram.sv */
//******************************
// Slot parameter memory
// One word of ten bytes per slot, byte-enable
// writes, read data registered one cycle
//******************************
`timescale 1ns/1ps
`default_nettype none
`include "fm_regs_defines.svh"

module fm_slot_ram import fm_regs_pkg::*; (
	input  logic         clk,
	input  logic         cen,
	input  slot_req_t    mem_req,
	output slot_params_t rdata
);

	localparam int NUM_BYTES = $bits(slot_params_t) / 8;

	slot_params_t mem [`FM_NUM_SLOTS];

	always_ff @(posedge clk) begin
		if (cen) begin
			if (mem_req.req && mem_req.we) begin
				for (int i = 0; i < NUM_BYTES; i++) begin
					if (mem_req.be[i])
						mem[mem_req.slot][i*8 +: 8] <= mem_req.wdata[i*8 +: 8];
				end
			end
			// Reads only when granted
			if (mem_req.req && !mem_req.we)
				rdata <= mem[mem_req.slot];
		end
	end

endmodule

`default_nettype wire

/* fm_slot_scan.sv */
//******************************
// Slot scanner
// Reads slots 0 to 23 in turn and presents each
// slot's parameters with its key-on bit
//******************************
`timescale 1ns/1ps
`default_nettype none
`include "fm_regs_defines.svh"

module fm_slot_scan import fm_regs_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         cen,
	output slot_req_t    rd_req,
	input  logic         rd_gnt,
	input  slot_params_t rdata,
	input  logic [23:0]  keyon,
	output slot_out_t    slot_out
);

	localparam logic [`FM_SLOT_BITS-1:0] LAST_SLOT = `FM_SLOT_BITS'(`FM_NUM_SLOTS - 1);

	logic [`FM_SLOT_BITS-1:0] slot_cnt;
	logic [`FM_SLOT_BITS-1:0] slot_q;
	logic                     vld_q;

	// Read request is always up
	always_comb begin
		rd_req.req   = 1'b1;
		rd_req.we    = 1'b0;
		rd_req.slot  = slot_cnt;
		rd_req.be    = '0;
		rd_req.wdata = '0;
	end

	always_ff @(posedge clk) begin
		if (cen) begin
			if (rst) begin
				slot_cnt <= '0;
				vld_q    <= 1'b0;
			end else begin
				vld_q <= rd_gnt;
				// Counter holds while the writer owns the port
				if (rd_gnt)
					slot_cnt <= (slot_cnt == LAST_SLOT) ? '0 : slot_cnt + 1'b1;
			end
		end
	end

	// Slot number travels alongside the memory read
	always_ff @(posedge clk) begin
		if (cen && rd_gnt)
			slot_q <= slot_cnt;
	end

	always_comb begin
		slot_out.valid  = vld_q;
		slot_out.slot   = slot_q;
		slot_out.ch     = slot_q[4:2];
		slot_out.op     = slot_q[1:0];
		slot_out.keyon  = keyon[slot_q];
		slot_out.params = rdata;
	end

endmodule

`default_nettype wire

/* fm_timers.sv */
//******************************
// Timers A and B
// Prescaled up counters that reload on overflow,
// set their flags and raise irq
//******************************
`timescale 1ns/1ps
`default_nettype none
`include "fm_regs_defines.svh"

module fm_timers (
	input  logic       clk,
	input  logic       rst,
	input  logic       cen,
	input  logic [9:0] value_a,
	input  logic [7:0] value_b,
	input  logic [5:0] timer_ctl,
	input  logic       timer_wr,
	output logic       flag_a,
	output logic       flag_b,
	output logic       irq
);

	localparam int PRE_A_W = $clog2(`FM_TIMER_A_PRESCALE);
	localparam int PRE_B_W = $clog2(`FM_TIMER_B_PRESCALE);
	localparam logic [PRE_A_W-1:0] PRE_A_LAST = PRE_A_W'(`FM_TIMER_A_PRESCALE - 1);
	localparam logic [PRE_B_W-1:0] PRE_B_LAST = PRE_B_W'(`FM_TIMER_B_PRESCALE - 1);

	logic [PRE_A_W-1:0] pre_a;
	logic [PRE_B_W-1:0] pre_b;
	logic [9:0]         cnt_a;
	logic [7:0]         cnt_b;
	logic               load_a;
	logic               load_b;
	logic               en_a;
	logic               en_b;
	logic               tick_a;
	logic               tick_b;

	assign tick_a = load_a && pre_a == PRE_A_LAST;
	assign tick_b = load_b && pre_b == PRE_B_LAST;
	assign irq    = flag_a | flag_b;

	always_ff @(posedge clk) begin
		if (cen) begin
			if (rst) begin
				pre_a  <= '0;
				pre_b  <= '0;
				cnt_a  <= '0;
				cnt_b  <= '0;
				{en_b, en_a, load_b, load_a} <= 4'd0;
				flag_a <= 1'b0;
				flag_b <= 1'b0;
			end else begin
				if (load_a) begin
					pre_a <= tick_a ? '0 : pre_a + 1'b1;
					if (tick_a) begin
						cnt_a <= (cnt_a == 10'h3FF) ? value_a : cnt_a + 10'd1;
						if (cnt_a == 10'h3FF && en_a)
							flag_a <= 1'b1;
					end
				end
				if (load_b) begin
					pre_b <= tick_b ? '0 : pre_b + 1'b1;
					if (tick_b) begin
						cnt_b <= (cnt_b == 8'hFF) ? value_b : cnt_b + 8'd1;
						if (cnt_b == 8'hFF && en_b)
							flag_b <= 1'b1;
					end
				end

				if (timer_wr) begin
					{en_b, en_a, load_b, load_a} <= timer_ctl[3:0];
					// A fresh load bit restarts from the written value
					if (timer_ctl[0] && !load_a) begin
						cnt_a <= value_a;
						pre_a <= '0;
					end
					if (timer_ctl[1] && !load_b) begin
						cnt_b <= value_b;
						pre_b <= '0;
					end
					if (timer_ctl[4])
						flag_a <= 1'b0;
					if (timer_ctl[5])
						flag_b <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* tb_fm_regs.sv */
//******************************
// Testbench for the FM register front end
// Drives the host port, keeps a reference of slot
// parameters and key-on bits, checks the scanner,
// timers and global outputs
//******************************
`timescale 1ns/1ps
`default_nettype none
`include "fm_regs_defines.svh"

module tb_fm_regs import fm_regs_pkg::*; ();

	localparam int BUSY_LIMIT = 50;
	localparam int SCAN_LIMIT = 300;
	localparam int FLAG_LIMIT = 400;

	logic       clk = 1'b0;
	logic       rst;
	logic       cen;
	host_wr_t   wr;
	logic       busy;
	slot_out_t  slot_out;
	logic       flag_a;
	logic       flag_b;
	logic       irq;
	logic [3:0] lfo;
	logic [8:0] pcm;
	logic       pcm_en;
	logic       eg_stop;
	logic       pg_stop;

	// Reference model of the slot memory and key-on state
	slot_params_t ref_params [`FM_NUM_SLOTS];
	logic [23:0]  ref_kon;
	logic [7:0]   blk_ref;

	always #10 clk = ~clk;

	fm_regs_top fm_regs_top_inst (
		.clk      (clk),
		.rst      (rst),
		.cen      (cen),
		.wr       (wr),
		.busy     (busy),
		.slot_out (slot_out),
		.flag_a   (flag_a),
		.flag_b   (flag_b),
		.irq      (irq),
		.lfo      (lfo),
		.pcm      (pcm),
		.pcm_en   (pcm_en),
		.eg_stop  (eg_stop),
		.pg_stop  (pg_stop)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [95:0] got,
			input logic [95:0] exp);
		string line;
		assert (got === exp) else begin
			line = $sformatf("CHECK FAILED at %0t: %s = %h, expected %h",
				$time, name, got, exp);
			fail_run(line);
		end
	endtask

	// Stop at the first failure of the bound checker
	always @(negedge clk) begin
		if (fm_regs_top_inst.fm_regs_assert_inst.error_count != 0)
			fail_run("the bound assertion checker reported a failure");
	end

	task automatic wait_not_busy();
		int n;
		n = 0;
		while (busy) begin
			@(negedge clk);
			n++;
			if (n > BUSY_LIMIT)
				fail_run("busy did not fall within the timeout");
		end
	endtask

	task automatic bus_cycle(input logic [1:0] a, input logic [7:0] d);
		wait_not_busy();
		wr.write = 1'b1;
		wr.addr  = a;
		wr.din   = d;
		@(negedge clk);
		wr.write = 1'b0;
		wait_not_busy();
	endtask

	task automatic write_reg(input logic bank, input logic [7:0] addr, input logic [7:0] d);
		bus_cycle({bank, 1'b0}, addr);
		bus_cycle({bank, 1'b1}, d);
	endtask

	// Field values 0..3 select operators 1, 3, 2, 4
	function automatic int slot_of(input logic bank, input logic [7:0] addr);
		int ch;
		int op;
		ch = bank * 3 + addr[1:0];
		case (addr[3:2])
			2'd0: op = 0;
			2'd1: op = 2;
			2'd2: op = 1;
			default: op = 3;
		endcase
		return ch * 4 + op;
	endfunction

	task automatic op_write(input logic bank, input logic [7:0] addr, input logic [7:0] d);
		int s;
		s = slot_of(bank, addr);
		write_reg(bank, addr, d);
		case (addr[7:4])
			4'h3: ref_params[s].dt_mul = d;
			4'h4: ref_params[s].tl = d;
			4'h5: ref_params[s].ks_ar = d;
			4'h6: ref_params[s].am_d1r = d;
			4'h7: ref_params[s].d2r = d;
			4'h8: ref_params[s].d1l_rr = d;
			default: ref_params[s].ssg_eg = d;
		endcase
	endtask

	// Base is A4h, A0h or B0h and channel is 0 to 5
	task automatic chan_write(input int ch, input logic [7:0] base, input logic [7:0] d);
		write_reg(ch >= 3, base + 8'(ch % 3), d);
		for (int op = 0; op < 4; op++) begin
			if (base == 8'hA0) begin
				ref_params[ch*4 + op].fnum_lo = d;
				ref_params[ch*4 + op].block_fnum_hi = blk_ref;
			end else if (base == 8'hB0) begin
				ref_params[ch*4 + op].fb_alg = d;
			end
		end
		if (base == 8'hA4)
			blk_ref = d;
	endtask

	task automatic kon_write(input logic [7:0] d);
		write_reg(1'b0, `FM_REG_KON, d);
		if (d[1:0] != 2'b11) begin
			for (int i = 0; i < 4; i++)
				ref_kon[(d[2] * 3 + d[1:0]) * 4 + i] = d[4+i];
		end
	endtask

	// One full pass of the scanner against the reference
	task automatic check_scan();
		int seen;
		int n;
		int s;
		seen = 0;
		n = 0;
		wait_not_busy();
		while (seen < `FM_NUM_SLOTS) begin
			@(negedge clk);
			n++;
			if (n > SCAN_LIMIT)
				fail_run("scanner did not present all slots within the timeout");
			if (slot_out.valid) begin
				s = slot_out.slot;
				check_value("slot_out.ch", slot_out.ch, s / 4);
				check_value("slot_out.op", slot_out.op, s % 4);
				check_value("slot_out.params", slot_out.params, ref_params[s]);
				check_value("slot_out.keyon", slot_out.keyon, ref_kon[s]);
				seen++;
			end
		end
	endtask

	task automatic wait_for_flags(input logic need_a, input logic need_b);
		int n;
		n = 0;
		while (!((flag_a || !need_a) && (flag_b || !need_b))) begin
			@(negedge clk);
			n++;
			if (n > FLAG_LIMIT)
				fail_run("timer flags did not rise within the bound");
		end
	endtask

	initial begin
		logic [7:0] addr;
		logic [7:0] d;
		slot_out_t  snap;
		int         len;
		void'($urandom(7160));
		wr      = '0;
		rst     = 1'b1;
		cen     = 1'b1;
		ref_kon = '0;
		blk_ref = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		// Every operator register of every slot and random extras
		for (int b = 0; b < 2; b++)
			for (int c = 0; c < 3; c++)
				for (int f = 0; f < 4; f++)
					for (int r = 3; r < 10; r++)
						op_write(1'(b), {4'(r), 2'(f), 2'(c)}, 8'($urandom));
		for (int k = 0; k < 40; k++) begin
			addr = {4'(3 + $urandom_range(6)), 2'($urandom), 2'($urandom_range(2))};
			op_write(1'($urandom), addr, 8'($urandom));
		end
		for (int c = 0; c < 6; c++) begin
			chan_write(c, 8'hA4, 8'($urandom));
			chan_write(c, 8'hA0, 8'($urandom));
			chan_write(c, 8'hB0, 8'($urandom));
		end
		check_scan();

		// Channel writes on a few channels and on unused addresses
		chan_write(2, 8'hA4, 8'h2C);
		chan_write(2, 8'hA0, 8'h9D);
		chan_write(5, 8'hB0, 8'h3A);
		chan_write(4, 8'hA4, 8'h61);
		write_reg(1'b0, 8'hB4, 8'hFF);
		write_reg(1'b1, 8'hA8, 8'h55);
		write_reg(1'b0, 8'h33, 8'hAA);
		check_scan();

		// Key-on writes including the unused channel code 3
		kon_write(8'hF0);
		kon_write(8'h51);
		kon_write(8'hA6);
		kon_write(8'h34);
		kon_write(8'hF3);
		kon_write(8'hC5);
		kon_write(8'h00);
		check_scan();

		// Second data write while the B1h write is still in flight
		bus_cycle(2'b00, 8'hB1);
		d = 8'($urandom);
		wr.write = 1'b1;
		wr.addr  = 2'b01;
		wr.din   = d;
		@(negedge clk);
		check_value("busy", busy, 1'b1);
		wr.din = ~d;
		@(negedge clk);
		wr.write = 1'b0;
		wait_not_busy();
		for (int op = 0; op < 4; op++)
			ref_params[4 + op].fb_alg = d;
		check_scan();

		// Timer A from 1020 and timer B from 254 with both flags enabled
		write_reg(1'b0, `FM_REG_CLKA1, 8'hFF);
		write_reg(1'b0, `FM_REG_CLKA2, 8'h00);
		write_reg(1'b0, `FM_REG_CLKB, 8'hFE);
		write_reg(1'b0, `FM_REG_TIMER, 8'h0F);
		wait_for_flags(1'b1, 1'b1);
		check_value("irq", irq, 1'b1);
		write_reg(1'b0, `FM_REG_TIMER, 8'h30);
		check_value("flag_a", flag_a, 1'b0);
		check_value("flag_b", flag_b, 1'b0);
		check_value("irq", irq, 1'b0);
		write_reg(1'b0, `FM_REG_TIMER, 8'h03);
		for (int n = 0; n < FLAG_LIMIT; n++) begin
			@(negedge clk);
			check_value("{flag_a, flag_b, irq}", {flag_a, flag_b, irq}, 3'b000);
		end

		// Clock enable low freezes the scanner and a running timer
		write_reg(1'b0, `FM_REG_TIMER, 8'h30);
		write_reg(1'b0, `FM_REG_TIMER, 8'h05);
		for (int k = 0; k < 4; k++) begin
			snap = slot_out;
			cen  = 1'b0;
			len  = $urandom_range(40, 10);
			for (int n = 0; n < len; n++) begin
				@(negedge clk);
				check_value("slot_out", slot_out, snap);
				check_value("flag_a", flag_a, 1'b0);
			end
			cen = 1'b1;
			@(negedge clk);
		end
		wait_for_flags(1'b1, 1'b0);

		// Global registers
		d = 8'($urandom);
		write_reg(1'b0, `FM_REG_LFO, d);
		check_value("lfo", lfo, d[3:0]);
		d = 8'($urandom);
		write_reg(1'b0, `FM_REG_PCM, d);
		check_value("pcm", pcm, {d, 1'b0});
		write_reg(1'b0, `FM_REG_PCM_EN, 8'h80);
		check_value("pcm_en", pcm_en, 1'b1);
		write_reg(1'b0, `FM_REG_TESTYM, 8'h28);
		check_value("eg_stop", eg_stop, 1'b1);
		check_value("pg_stop", pg_stop, 1'b1);
		write_reg(1'b0, `FM_REG_TESTYM, 8'h20);
		check_value("pg_stop", pg_stop, 1'b0);

		if (fm_regs_top_inst.fm_regs_assert_inst.error_count == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			fail_run("the bound assertion checker reported a failure");
		end
	end

endmodule

`default_nettype wire
